// File: Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_usb_bulk_out
FILELIST  = build.f
OBJ_DIR   = obj_dir
PASS_MSG  = Verification passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: build.f
+incdir+src
src/usb_bulk_pkg.sv
src/axis_byte_if.sv
src/packet_fifo.sv
src/ep_bulk_out.sv
src/ep_rx_router.sv
src/ep_sink_arbiter.sv
src/usb_bulk_out_top.sv
test/tb_usb_bulk_out.sv

// File: src/axis_byte_if.sv
`default_nettype none

// Byte-wide valid/ready stream
interface axis_byte_if;
  import usb_bulk_pkg::*;

  logic  tvalid;
  logic  tready;
  logic  tkeep;  // Low with tlast marks a zero-length packet
  logic  tlast;
  byte_t tdata;

  modport src(output tvalid, output tkeep, output tlast, output tdata, input tready);

  modport dst(input tvalid, input tkeep, input tlast, input tdata, output tready);

endinterface

`default_nettype wire

// File: src/ep_bulk_out.sv
`default_nettype none

`include "usb_bulk_params.svh"

module ep_bulk_out (
  input  wire      clock,
  input  wire      rst_n_i,
  input  wire      set_conf_i,  // From the control pipe
  input  wire      clr_conf_i,
  input  wire      selected_i,  // Token addresses this endpoint
  input  wire      rx_error_i,  // CRC16 failure or timeout
  input  wire      ack_sent_i,
  output logic     ep_ready_o,
  output logic     stalled_o,
  output logic     parity_o,    // Data toggle
  axis_byte_if.dst s_if,
  axis_byte_if.src m_if
);
  import usb_bulk_pkg::*;

  localparam int DEPTH = `USB_FIFO_DEPTH;
  localparam int MAX_PKT = `USB_MAX_PACKET;

  ep_state_e state_q;
  logic      parity_q;
  logic      ready_q;
  logic      fifo_rst_n_q;
  fifo_lvl_t level_w;
  fifo_lvl_t room_w;
  logic      short_w;  // Less than one packet of space

  axis_byte_if fifo_in ();

  assign stalled_o  = state_q == EP_HALT;
  assign parity_o   = parity_q;
  assign ep_ready_o = ready_q;

  assign room_w  = fifo_lvl_t'(DEPTH) - level_w;
  assign short_w = room_w < fifo_lvl_t'(MAX_PKT);

  // Bytes pass to the FIFO only while receiving
  assign fifo_in.tvalid = s_if.tvalid && state_q == EP_RECV;
  assign fifo_in.tkeep  = s_if.tkeep;
  assign fifo_in.tlast  = s_if.tlast;
  assign fifo_in.tdata  = s_if.tdata;
  assign s_if.tready    = fifo_in.tready && state_q == EP_RECV;

  // Flags and FIFO reset, also cleared by a new configuration
  always_ff @(posedge clock) begin
    if (!rst_n_i || set_conf_i) begin
      fifo_rst_n_q <= 1'b0;
      parity_q     <= 1'b0;
      ready_q      <= 1'b0;
    end else begin
      fifo_rst_n_q <= 1'b1;
      if (state_q == EP_SAVE && ack_sent_i) begin
        parity_q <= ~parity_q;
      end
      if (state_q == EP_IDLE) begin
        ready_q <= 1'b1;
      end else if (state_q == EP_HALT || state_q == EP_FULL) begin
        ready_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (!rst_n_i || clr_conf_i) begin
      state_q <= EP_HALT;
    end else begin
      case (state_q)
        EP_HALT: begin
          if (set_conf_i) state_q <= EP_IDLE;
        end
        EP_IDLE: begin
          if (selected_i) state_q <= EP_RECV;
        end
        EP_RECV: begin
          // Lost selection mid-packet is a protocol error
          if (!selected_i || rx_error_i) begin
            state_q <= EP_HALT;
          end else if (s_if.tvalid && s_if.tready && s_if.tlast) begin
            state_q <= EP_SAVE;
          end
        end
        EP_SAVE: begin
          if (ack_sent_i || rx_error_i) begin
            state_q <= short_w ? EP_FULL : EP_IDLE;
          end
        end
        EP_FULL: begin
          if (!short_w) begin
            state_q <= EP_IDLE;
          end else if (selected_i) begin
            state_q <= EP_HALT;  // Host sent to a full endpoint
          end
        end
        default: state_q <= EP_HALT;
      endcase
    end
  end

  packet_fifo u_fifo (
    .clock   (clock),
    .rst_n_i (fifo_rst_n_q),
    .drop_i  (rx_error_i),
    .save_i  (ack_sent_i && state_q == EP_SAVE),
    .level_o (level_w),
    .s_if    (fifo_in),
    .m_if    (m_if)
  );

  // Router only forwards bytes to the selected endpoint
  a_rx_only_when_recv: assert property (
    @(posedge clock) disable iff (!rst_n_i)
    s_if.tvalid && s_if.tready |-> state_q == EP_RECV && selected_i
  ) else $error("ep_bulk_out: byte transfer outside receive");

endmodule

`default_nettype wire

// File: src/ep_rx_router.sv
`default_nettype none

`include "usb_bulk_params.svh"

module ep_rx_router (
  input  wire                        clock,
  input  wire                        rst_n_i,
  input  wire                        token_valid_i,
  input  wire usb_bulk_pkg::ep_idx_t token_ep_i,
  input  wire                        rx_error_i,
  input  wire                        ack_sent_i,
  input  wire                        s_tvalid_i,
  input  wire                        s_tkeep_i,
  input  wire                        s_tlast_i,
  input  wire usb_bulk_pkg::byte_t   s_tdata_i,
  output logic                       s_tready_o,
  output logic [`USB_NUM_EP-1:0]     ep_sel_o,
  output logic [`USB_NUM_EP-1:0]     ep_err_o,
  output logic [`USB_NUM_EP-1:0]     ep_ack_o,
  axis_byte_if.src                   ep_if [`USB_NUM_EP]
);
  import usb_bulk_pkg::*;

  localparam int NUM_EP = `USB_NUM_EP;

  ep_idx_t           sel_q;
  logic              busy_q;  // Token active
  logic              hit_q;   // Latched index names a real endpoint
  logic [NUM_EP-1:0] rdy_w;

  always_ff @(posedge clock) begin
    if (!rst_n_i) begin
      sel_q  <= '0;
      busy_q <= 1'b0;
      hit_q  <= 1'b0;
    end else if (!token_valid_i) begin
      busy_q <= 1'b0;
    end else if (!busy_q) begin
      sel_q  <= token_ep_i;
      busy_q <= 1'b1;
      hit_q  <= int'(token_ep_i) < NUM_EP;
    end
  end

  for (genvar i = 0; i < NUM_EP; i++) begin : g_ep
    assign ep_sel_o[i] = busy_q && sel_q == ep_idx_t'(i);
    assign ep_err_o[i] = rx_error_i && ep_sel_o[i];
    assign ep_ack_o[i] = ack_sent_i && ep_sel_o[i];

    assign ep_if[i].tvalid = s_tvalid_i && ep_sel_o[i];
    assign ep_if[i].tkeep  = s_tkeep_i;
    assign ep_if[i].tlast  = s_tlast_i;
    assign ep_if[i].tdata  = s_tdata_i;

    assign rdy_w[i] = ep_if[i].tready && ep_sel_o[i];
  end

  // Bytes for an unknown endpoint are swallowed
  assign s_tready_o = busy_q && (!hit_q || |rdy_w);

  // A status pulse for a real endpoint reaches exactly one endpoint
  a_status_to_one: assert property (
    @(posedge clock) disable iff (!rst_n_i)
    (ack_sent_i || rx_error_i) && hit_q |-> $onehot(ep_sel_o)
  ) else $error("ep_rx_router: status pulse without a selected endpoint");

endmodule

`default_nettype wire

// File: src/ep_sink_arbiter.sv
`default_nettype none

`include "usb_bulk_params.svh"

module ep_sink_arbiter (
  input  wire                     clock,
  input  wire                     rst_n_i,
  axis_byte_if.dst                ep_if [`USB_NUM_EP],
  output logic                    m_tvalid_o,
  input  wire                     m_tready_i,
  output logic                    m_tlast_o,
  output usb_bulk_pkg::byte_t     m_tdata_o,
  output usb_bulk_pkg::ep_idx_t   m_tdest_o  // Source endpoint of the frame
);
  import usb_bulk_pkg::*;

  localparam int NUM_EP = `USB_NUM_EP;

  logic [NUM_EP-1:0] valid_w;
  logic [NUM_EP-1:0] last_w;
  byte_t             data_w [NUM_EP];
  ep_idx_t           grant_q;
  ep_idx_t           pick_w;
  logic              found_w;
  logic              lock_q;  // Frame in progress
  logic              done_w;

  for (genvar i = 0; i < NUM_EP; i++) begin : g_ep
    assign valid_w[i] = ep_if[i].tvalid;
    assign last_w[i]  = ep_if[i].tlast;
    assign data_w[i]  = ep_if[i].tdata;
    assign ep_if[i].tready = lock_q && grant_q == ep_idx_t'(i) && m_tready_i;
  end

  // Nearest requester after the last winner
  always_comb begin
    int unsigned idx;
    pick_w  = grant_q;
    found_w = 1'b0;
    for (int k = NUM_EP; k >= 1; k--) begin
      idx = (int'(grant_q) + k) % NUM_EP;
      if (valid_w[idx]) begin
        pick_w  = ep_idx_t'(idx);
        found_w = 1'b1;
      end
    end
  end

  assign m_tvalid_o = lock_q && valid_w[grant_q];
  assign m_tlast_o  = last_w[grant_q];
  assign m_tdata_o  = data_w[grant_q];
  assign m_tdest_o  = grant_q;
  assign done_w     = m_tvalid_o && m_tready_i && m_tlast_o;

  always_ff @(posedge clock) begin
    if (!rst_n_i) begin
      grant_q <= ep_idx_t'(NUM_EP - 1);  // First pick is endpoint 0
      lock_q  <= 1'b0;
    end else if (!lock_q) begin
      if (found_w) begin
        grant_q <= pick_w;
        lock_q  <= 1'b1;
      end
    end else if (done_w) begin
      lock_q <= 1'b0;
    end
  end

  // A stalled byte stays on the output with its endpoint tag
  a_hold_on_stall: assert property (
    @(posedge clock) disable iff (!rst_n_i)
    m_tvalid_o && !m_tready_i |=>
      m_tvalid_o && $stable(m_tdest_o) && $stable(m_tdata_o) && $stable(m_tlast_o)
  ) else $error("ep_sink_arbiter: output changed while stalled");

endmodule

`default_nettype wire

// File: src/packet_fifo.sv
`default_nettype none

`include "usb_bulk_params.svh"

module packet_fifo (
  input  wire                     clock,
  input  wire                     rst_n_i,
  input  wire                     drop_i,   // Rewind to the last commit
  input  wire                     save_i,   // Commit the packet just written
  output usb_bulk_pkg::fifo_lvl_t level_o,  // Includes uncommitted bytes
  axis_byte_if.dst                s_if,
  axis_byte_if.src                m_if
);
  import usb_bulk_pkg::*;

  localparam int DEPTH = `USB_FIFO_DEPTH;
  localparam int MAX_PKT = `USB_MAX_PACKET;

  byte_t            data_mem [DEPTH];
  logic [DEPTH-1:0] last_q;
  fifo_lvl_t        wr_q;   // Next write slot
  fifo_lvl_t        cmt_q;  // End of committed data
  fifo_lvl_t        vis_q;  // End of readable data, one short of cmt_q while a byte is held
  fifo_lvl_t        rd_q;
  pkt_cnt_t         cnt_q;  // Bytes in the packet being written
  logic             full_w;
  logic             held_w;
  logic             wr_en;
  logic             rd_en;

  assign level_o = wr_q - rd_q;
  assign full_w  = level_o == fifo_lvl_t'(DEPTH);
  assign held_w  = vis_q != cmt_q;

  assign s_if.tready = !full_w;
  assign wr_en = s_if.tvalid && s_if.tkeep && !full_w;  // ZLP carries no byte
  assign rd_en = (vis_q != rd_q) && (!m_if.tvalid || m_if.tready);

  assign m_if.tkeep = 1'b1;

  always_ff @(posedge clock) begin
    if (wr_en) begin
      data_mem[fifo_ptr_t'(wr_q)] <= s_if.tdata;
    end
  end

  // Last flag is stored only for a short packet's final byte
  always_ff @(posedge clock) begin
    if (wr_en) begin
      last_q[fifo_ptr_t'(wr_q)] <= s_if.tlast && (cnt_q != pkt_cnt_t'(MAX_PKT - 1));
    end
    // ZLP after a full-size packet closes the frame on the held byte
    if (save_i && !drop_i && cnt_q == '0 && held_w) begin
      last_q[fifo_ptr_t'(vis_q)] <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (!rst_n_i) begin
      wr_q  <= '0;
      cmt_q <= '0;
      vis_q <= '0;
      cnt_q <= '0;
    end else if (drop_i) begin
      wr_q  <= cmt_q;
      cnt_q <= '0;
    end else if (save_i) begin
      cmt_q <= wr_q;
      // Full-size packet keeps its last byte back until the next save
      vis_q <= (cnt_q == pkt_cnt_t'(MAX_PKT)) ? wr_q - 1'b1 : wr_q;
      cnt_q <= '0;
    end else if (wr_en) begin
      wr_q  <= wr_q + 1'b1;
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // Registered output stage
  always_ff @(posedge clock) begin
    if (!rst_n_i) begin
      rd_q        <= '0;
      m_if.tvalid <= 1'b0;
    end else if (rd_en) begin
      rd_q        <= rd_q + 1'b1;
      m_if.tvalid <= 1'b1;
    end else if (m_if.tready) begin
      m_if.tvalid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (rd_en) begin
      m_if.tdata <= data_mem[fifo_ptr_t'(rd_q)];
      m_if.tlast <= last_q[fifo_ptr_t'(rd_q)];
    end
  end

  // The endpoint admits a packet only with room for all of it
  a_no_write_when_full: assert property (
    @(posedge clock) disable iff (!rst_n_i)
    s_if.tvalid && s_if.tkeep |-> !full_w
  ) else $error("packet_fifo: byte offered while full");

endmodule

`default_nettype wire

// File: src/usb_bulk_out_top.sv
`default_nettype none

`include "usb_bulk_params.svh"

module usb_bulk_out_top (
  input  wire                        clock,
  input  wire                        rst_n_i,
  input  wire                        set_conf_i,
  input  wire                        clr_conf_i,
  input  wire                        token_valid_i,
  input  wire usb_bulk_pkg::ep_idx_t token_ep_i,
  input  wire                        rx_error_i,
  input  wire                        ack_sent_i,
  input  wire                        s_tvalid_i,  // From the packet decoder
  output logic                       s_tready_o,
  input  wire                        s_tkeep_i,
  input  wire                        s_tlast_i,
  input  wire usb_bulk_pkg::byte_t   s_tdata_i,
  output logic                       m_tvalid_o,  // Merged endpoint frames
  input  wire                        m_tready_i,
  output logic                       m_tlast_o,
  output usb_bulk_pkg::byte_t        m_tdata_o,
  output usb_bulk_pkg::ep_idx_t      m_tdest_o,
  output logic [`USB_NUM_EP-1:0]     ep_ready_o,
  output logic [`USB_NUM_EP-1:0]     stalled_o,
  output logic [`USB_NUM_EP-1:0]     parity_o
);

  logic [`USB_NUM_EP-1:0] ep_sel_w;
  logic [`USB_NUM_EP-1:0] ep_err_w;
  logic [`USB_NUM_EP-1:0] ep_ack_w;

  axis_byte_if rx_if [`USB_NUM_EP] ();  // Router to endpoints
  axis_byte_if tx_if [`USB_NUM_EP] ();  // Endpoints to arbiter

  ep_rx_router u_router (
    .clock         (clock),
    .rst_n_i       (rst_n_i),
    .token_valid_i (token_valid_i),
    .token_ep_i    (token_ep_i),
    .rx_error_i    (rx_error_i),
    .ack_sent_i    (ack_sent_i),
    .s_tvalid_i    (s_tvalid_i),
    .s_tkeep_i     (s_tkeep_i),
    .s_tlast_i     (s_tlast_i),
    .s_tdata_i     (s_tdata_i),
    .s_tready_o    (s_tready_o),
    .ep_sel_o      (ep_sel_w),
    .ep_err_o      (ep_err_w),
    .ep_ack_o      (ep_ack_w),
    .ep_if         (rx_if)
  );

  for (genvar i = 0; i < `USB_NUM_EP; i++) begin : g_ep
    ep_bulk_out u_ep (
      .clock      (clock),
      .rst_n_i    (rst_n_i),
      .set_conf_i (set_conf_i),
      .clr_conf_i (clr_conf_i),
      .selected_i (ep_sel_w[i]),
      .rx_error_i (ep_err_w[i]),
      .ack_sent_i (ep_ack_w[i]),
      .ep_ready_o (ep_ready_o[i]),
      .stalled_o  (stalled_o[i]),
      .parity_o   (parity_o[i]),
      .s_if       (rx_if[i]),
      .m_if       (tx_if[i])
    );
  end

  ep_sink_arbiter u_arbiter (
    .clock      (clock),
    .rst_n_i    (rst_n_i),
    .ep_if      (tx_if),
    .m_tvalid_o (m_tvalid_o),
    .m_tready_i (m_tready_i),
    .m_tlast_o  (m_tlast_o),
    .m_tdata_o  (m_tdata_o),
    .m_tdest_o  (m_tdest_o)
  );

endmodule

`default_nettype wire

// File: src/usb_bulk_params.svh
`ifndef USB_BULK_PARAMS_SVH
`define USB_BULK_PARAMS_SVH

// Number of bulk OUT endpoints
`define USB_NUM_EP 3

// HS bulk packet size, scaled down from 512
`define USB_MAX_PACKET 16

// Bytes per endpoint FIFO, power of two and at least two packets
`define USB_FIFO_DEPTH 64

`endif

// File: src/usb_bulk_pkg.sv
`default_nettype none

`include "usb_bulk_params.svh"

package usb_bulk_pkg;

  typedef logic [7:0] byte_t;

  // Endpoint index, one bit minimum
  typedef logic [(`USB_NUM_EP > 1 ? $clog2(`USB_NUM_EP) : 1)-1:0] ep_idx_t;

  typedef logic [$clog2(`USB_FIFO_DEPTH)-1:0] fifo_ptr_t;  // FIFO address
  typedef logic [$clog2(`USB_FIFO_DEPTH):0] fifo_lvl_t;    // Fill level, 0 to depth

  // Bytes within one packet, 0 to max packet
  typedef logic [$clog2(`USB_MAX_PACKET):0] pkt_cnt_t;

  typedef enum logic [2:0] {
    EP_HALT,
    EP_IDLE,
    EP_RECV,
    EP_SAVE,
    EP_FULL
  } ep_state_e;

endpackage

`default_nettype wire

// File: test/tb_usb_bulk_out.sv
`default_nettype none

`include "usb_bulk_params.svh"

module tb_usb_bulk_out;
  import usb_bulk_pkg::*;

  localparam int NUM_EP        = `USB_NUM_EP;
  localparam int MAX_PKT       = `USB_MAX_PACKET;
  localparam int DRIVE_DLY     = 2;
  localparam int MODE_ACK      = 0;
  localparam int MODE_ERR_SAVE = 1;  // Error after the last byte
  localparam int MODE_ERR_RECV = 2;  // Error in the middle of the packet

  logic              clock = 1'b0;
  logic              rst_n_i;
  logic              set_conf_i;
  logic              clr_conf_i;
  logic              token_valid_i;
  ep_idx_t           token_ep_i;
  logic              rx_error_i;
  logic              ack_sent_i;
  logic              s_tvalid_i;
  logic              s_tready_o;
  logic              s_tkeep_i;
  logic              s_tlast_i;
  byte_t             s_tdata_i;
  logic              m_tvalid_o;
  logic              m_tready_i;
  logic              m_tlast_o;
  byte_t             m_tdata_o;
  ep_idx_t           m_tdest_o;
  logic [NUM_EP-1:0] ep_ready_o;
  logic [NUM_EP-1:0] stalled_o;
  logic [NUM_EP-1:0] parity_o;

  logic [8:0]        exp_q [NUM_EP][$];  // {tlast, tdata} still to come out
  logic [NUM_EP-1:0] par_model;
  logic [NUM_EP-1:0] open_model;         // Last acked packet was full-size
  integer            seed = 32'h2dd9_7396;
  int                bytes_sent = 0;
  int                cycles = 0;
  logic              bp_en = 1'b0;
  logic              in_frame = 1'b0;
  ep_idx_t           cur_dest;

  usb_bulk_out_top uut (
    .clock         (clock),
    .rst_n_i       (rst_n_i),
    .set_conf_i    (set_conf_i),
    .clr_conf_i    (clr_conf_i),
    .token_valid_i (token_valid_i),
    .token_ep_i    (token_ep_i),
    .rx_error_i    (rx_error_i),
    .ack_sent_i    (ack_sent_i),
    .s_tvalid_i    (s_tvalid_i),
    .s_tready_o    (s_tready_o),
    .s_tkeep_i     (s_tkeep_i),
    .s_tlast_i     (s_tlast_i),
    .s_tdata_i     (s_tdata_i),
    .m_tvalid_o    (m_tvalid_o),
    .m_tready_i    (m_tready_i),
    .m_tlast_o     (m_tlast_o),
    .m_tdata_o     (m_tdata_o),
    .m_tdest_o     (m_tdest_o),
    .ep_ready_o    (ep_ready_o),
    .stalled_o     (stalled_o),
    .parity_o      (parity_o)
  );

  always #20 clock = ~clock;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] want);
    if (got !== want) begin
      fail_run($sformatf("Mismatch on %s: got 0x%0h, expected 0x%0h", name, got, want));
    end
  endtask

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // An acked packet joins its endpoint's open frame and a short one closes it
  function automatic void model_ack(input int ep, input byte_t data [$], input int len);
    logic [8:0] tail;
    logic       last;
    if (len == 0) begin
      // ZLP ends a frame still open after a full-size packet
      if (open_model[ep]) begin
        tail = exp_q[ep].pop_back();
        exp_q[ep].push_back(tail | 9'h100);
      end
    end else begin
      for (int i = 0; i < len; i++) begin
        last = (i == len - 1) && (len < MAX_PKT);
        exp_q[ep].push_back({last, data[i]});
      end
    end
    open_model[ep] = (len == MAX_PKT);
  endfunction

  function automatic int pending_bytes();
    int sum = 0;
    for (int i = 0; i < NUM_EP; i++) begin
      sum += exp_q[i].size();
    end
    return sum;
  endfunction

  // Limit grows with the traffic sent so far
  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles > bytes_sent * 4 + 2000) begin
      fail_run($sformatf("Timeout after %0d cycles with %0d bytes sent", cycles, bytes_sent));
    end
  end

  always @(posedge clock) begin
    #DRIVE_DLY;
    m_tready_i = bp_en ? rand_below(2) != 0 : 1'b1;  // Random back-pressure when enabled
  end

  // Output monitor samples mid-cycle where the stream is stable
  always @(negedge clock) begin : monitor
    logic [8:0] want;
    if (rst_n_i && m_tvalid_o && m_tready_i) begin
      if (int'(m_tdest_o) >= NUM_EP) begin
        fail_run("Output byte is tagged with an endpoint index that does not exist");
      end
      if (exp_q[m_tdest_o].size() == 0) begin
        fail_run($sformatf("Unexpected output byte 0x%0h from endpoint %0d",
                           m_tdata_o, m_tdest_o));
      end
      if (in_frame) check_value("m_tdest_o", m_tdest_o, cur_dest);  // No interleaving
      want = exp_q[m_tdest_o].pop_front();
      check_value("m_tdata_o", m_tdata_o, want[7:0]);
      check_value("m_tlast_o", m_tlast_o, want[8]);
      in_frame = !m_tlast_o;
      cur_dest = m_tdest_o;
    end
  end

  task automatic send_beat(input byte_t data, input logic keep, input logic last);
    s_tvalid_i = 1'b1;
    s_tkeep_i  = keep;
    s_tlast_i  = last;
    s_tdata_i  = data;
    @(negedge clock);
    while (!s_tready_o) @(negedge clock);
    @(posedge clock);
    #DRIVE_DLY;
    s_tvalid_i = 1'b0;
  endtask

  task automatic wait_ready(input int ep);
    @(negedge clock);
    while (!ep_ready_o[ep]) @(negedge clock);
  endtask

  // One token, the packet bytes, then ack or error
  task automatic send_packet(input int ep, input int len, input int mode);
    byte_t data [$];
    int    stop_at;
    for (int i = 0; i < len; i++) data.push_back(byte_t'($random(seed)));
    stop_at = (mode == MODE_ERR_RECV) ? len / 2 : len;
    bytes_sent += len + 1;
    wait_ready(ep);
    @(posedge clock);
    #DRIVE_DLY;
    token_valid_i = 1'b1;
    token_ep_i    = ep_idx_t'(ep);
    if (len == 0) send_beat(8'h00, 1'b0, 1'b1);  // ZLP
    for (int i = 0; i < stop_at; i++) send_beat(data[i], 1'b1, i == len - 1);
    // Token drops together with the status pulse
    token_valid_i = 1'b0;
    if (mode == MODE_ACK) begin
      ack_sent_i = 1'b1;
      par_model[ep] = ~par_model[ep];
      model_ack(ep, data, len);
    end else begin
      rx_error_i = 1'b1;
    end
    @(posedge clock);
    #DRIVE_DLY;
    ack_sent_i = 1'b0;
    rx_error_i = 1'b0;
    repeat (2) @(posedge clock);
    @(negedge clock);
    check_value("parity_o", parity_o, par_model);
  endtask

  task automatic wait_drain();
    @(negedge clock);
    while (pending_bytes() != 0) @(negedge clock);
    repeat (4) @(negedge clock);
    check_value("m_tvalid_o", m_tvalid_o, 0);
  endtask

  task automatic configure();
    @(posedge clock);
    #DRIVE_DLY;
    set_conf_i = 1'b1;
    @(posedge clock);
    #DRIVE_DLY;
    set_conf_i = 1'b0;
    par_model  = '0;
    open_model = '0;
    repeat (3) @(posedge clock);
    @(negedge clock);
    check_value("stalled_o", stalled_o, 0);
    check_value("ep_ready_o", ep_ready_o, {NUM_EP{1'b1}});
    check_value("parity_o", parity_o, 0);
  endtask

  initial begin : stimulus
    int ep;
    int chunks;
    rst_n_i       = 1'b0;
    set_conf_i    = 1'b0;
    clr_conf_i    = 1'b0;
    token_valid_i = 1'b0;
    token_ep_i    = '0;
    rx_error_i    = 1'b0;
    ack_sent_i    = 1'b0;
    s_tvalid_i    = 1'b0;
    s_tkeep_i     = 1'b0;
    s_tlast_i     = 1'b0;
    s_tdata_i     = '0;
    m_tready_i    = 1'b1;
    par_model     = '0;
    open_model    = '0;
    repeat (16) @(posedge clock);
    #DRIVE_DLY;
    rst_n_i = 1'b1;
    @(negedge clock);
    check_value("stalled_o", stalled_o, {NUM_EP{1'b1}});
    check_value("ep_ready_o", ep_ready_o, 0);
    check_value("m_tvalid_o", m_tvalid_o, 0);
    check_value("s_tready_o", s_tready_o, 0);
    configure();

    for (int i = 0; i < NUM_EP; i++) send_packet(i, 3 + 4 * i, MODE_ACK);
    wait_drain();

    // Frames joined from full-size chunks
    send_packet(0, MAX_PKT, MODE_ACK);
    send_packet(0, MAX_PKT, MODE_ACK);
    send_packet(0, 7, MODE_ACK);
    send_packet(1, MAX_PKT, MODE_ACK);
    send_packet(1, MAX_PKT, MODE_ACK);
    send_packet(1, 0, MODE_ACK);
    send_packet(2, MAX_PKT, MODE_ACK);
    send_packet(2, 0, MODE_ACK);
    send_packet(2, 0, MODE_ACK);  // Lone ZLP adds nothing
    wait_drain();

    // Errored packets vanish and a receive error halts the endpoint
    send_packet(1, 10, MODE_ERR_SAVE);
    send_packet(0, MAX_PKT, MODE_ACK);
    send_packet(0, 9, MODE_ERR_SAVE);
    send_packet(0, 3, MODE_ACK);
    send_packet(2, 12, MODE_ERR_RECV);
    check_value("stalled_o", stalled_o, 3'b100);
    wait_drain();
    check_value("stalled_o", stalled_o, 3'b100);
    configure();

    // Interleaved frames under back-pressure
    bp_en = 1'b1;
    for (int f = 0; f < 14; f++) begin
      ep     = rand_below(NUM_EP);
      chunks = rand_below(3);
      for (int c = 0; c < chunks; c++) begin
        send_packet(ep, MAX_PKT, rand_below(6) == 0 ? MODE_ERR_SAVE : MODE_ACK);
      end
      send_packet(ep, rand_below(MAX_PKT), MODE_ACK);
    end
    wait_drain();
    bp_en = 1'b0;

    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire
